//--- smi_settings.svh
`ifndef SMI_SETTINGS_SVH
`define SMI_SETTINGS_SVH

// clocking
`define SMI_REF_CLK_MHZ 50            // system clk in MHz
`define SMI_MDC_KHZ     5000          // target mdc rate

// status polling interval in clk cycles, short for simulation
`define SMI_POLL_CYCLES 32'd400

// command queue depth, also the monitor's starting credit count
`define SMI_FIFO_DEPTH  4

// phy addressing and register map
`define SMI_PHY_ADDR    5'd1
`define SMI_REG_CTRL    5'd0          // basic control register
`define SMI_REG_STATUS  5'd17         // phy-specific status

// configuration word for the control register
`define SMI_CTRL_VALUE  16'h1300      // autoneg enable + restart

`endif

//--- smi_pkg.sv
package smi_pkg;

  // clause-22 opcode, same bit pattern as it goes on the wire
  typedef enum logic [1:0] {
    SMI_OP_WRITE = 2'b01,
    SMI_OP_READ  = 2'b10
  } smi_op_e;

  // one management command as queued between monitor and engine
  typedef struct packed {
    smi_op_e     op;            // read or write
    logic [4:0]  reg_addr;      // phy register number
    logic [15:0] wdata;         // ignored for reads
  } smi_cmd_t;

  // link speed as reported to the outside
  typedef enum logic [1:0] {
    SPEED_10M     = 2'b00,
    SPEED_100M    = 2'b01,
    SPEED_1000M   = 2'b10,
    SPEED_UNKNOWN = 2'b11       // nothing decoded yet
  } eth_speed_e;

endpackage

//--- smi_cmd_if.sv
// command channel with credit return
interface smi_cmd_if;
  import smi_pkg::*;

  logic     valid;              // one-cycle push strobe
  smi_cmd_t cmd;                // command payload
  logic     credit;             // one-cycle credit return

  modport src (
    output valid,
    output cmd,
    input  credit
  );

  modport dst (
    input  valid,
    input  cmd,
    output credit
  );

endinterface

//--- smi_link_monitor.sv
`include "smi_settings.svh"

module smi_link_monitor (
  input  logic                clk,
  input  logic                rst_n,
  smi_cmd_if.src              cmd,
  input  logic                rdata_valid,
  input  logic [15:0]         rdata,
  output logic                link,
  output smi_pkg::eth_speed_e speed,
  output logic [1:0]          led
);
  import smi_pkg::*;

  localparam int CRED_W = $clog2(`SMI_FIFO_DEPTH + 1);

  typedef enum logic [2:0] {
    ST_CFG_REQ,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_DECODE,
    ST_POLL
  } mon_state_e;

  mon_state_e        state;
  logic [CRED_W-1:0] credit_cnt;   // free slots in the fifo
  logic              take;         // command leaves this cycle
  logic [15:0]       status_q;     // last status word read
  logic [31:0]       timer;        // poll interval count
  eth_speed_e        dec_speed;

  assign take = ((state == ST_CFG_REQ) || (state == ST_RD_REQ)) && (credit_cnt != '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= ST_CFG_REQ;
    else
    begin
      case (state)
        ST_CFG_REQ:
          if (take)
            state <= ST_RD_REQ;
        ST_RD_REQ:
          if (take)
            state <= ST_RD_WAIT;
        ST_RD_WAIT:
          if (rdata_valid)
            state <= ST_DECODE;
        ST_DECODE:
          state <= ST_POLL;
        ST_POLL:
          if (timer == `SMI_POLL_CYCLES - 32'd1)
            state <= ST_RD_REQ;
        default:
          state <= ST_CFG_REQ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      timer <= '0;
    else if (state == ST_POLL)
      timer <= timer + 32'd1;
    else
      timer <= '0;
  end

  // producer side of the credit scheme
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      credit_cnt <= CRED_W'(`SMI_FIFO_DEPTH);
      cmd.valid  <= 1'b0;
    end
    else
    begin
      credit_cnt <= credit_cnt - CRED_W'(take) + CRED_W'(cmd.credit);
      cmd.valid  <= take;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take && (state == ST_CFG_REQ))
      cmd.cmd <= '{op: SMI_OP_WRITE, reg_addr: `SMI_REG_CTRL, wdata: `SMI_CTRL_VALUE};
    else if (take)
      cmd.cmd <= '{op: SMI_OP_READ, reg_addr: `SMI_REG_STATUS, wdata: 16'h0000};
  end

  always_ff @(posedge clk)
  begin
    if (rdata_valid && (state == ST_RD_WAIT))
      status_q <= rdata;
  end

  // bits 15:14 carry the resolved speed, 1x is gigabit
  always_comb
  begin
    case (status_q[15:14])
      2'b00:   dec_speed = SPEED_10M;
      2'b01:   dec_speed = SPEED_100M;
      default: dec_speed = SPEED_1000M;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      link  <= 1'b0;
      speed <= SPEED_UNKNOWN;
    end
    else if (state == ST_DECODE)
    begin
      link <= status_q[10];                  // bit 10 is link up
      if (status_q[10])
        speed <= dec_speed;                  // speed held while down
    end
  end

  // led follows link and speed one edge later
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      led <= 2'b11;
    else if (!link)
      led <= 2'b11;
    else
    begin
      case (speed)
        SPEED_10M:   led <= 2'b10;
        SPEED_100M:  led <= 2'b01;
        SPEED_1000M: led <= 2'b00;
        default:     led <= 2'b11;
      endcase
    end
  end

  // a send without credit or a surplus credit return leaves this range
  a_credit_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= CRED_W'(`SMI_FIFO_DEPTH));

endmodule

//--- smi_cmd_fifo.sv
`include "smi_settings.svh"

module smi_cmd_fifo (
  input  logic   clk,
  input  logic   rst_n,
  smi_cmd_if.dst wr,
  smi_cmd_if.src rd
);
  import smi_pkg::*;

  localparam int DEPTH = `SMI_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  smi_cmd_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             eng_credit;   // engine can take one frame
  logic             pop;

  // head goes out as soon as the engine holds a free slot
  assign pop      = (count != '0) && eng_credit;
  assign rd.valid = pop;
  assign rd.cmd   = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (wr.valid)
      mem[wr_ptr] <= wr.cmd;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      eng_credit <= 1'b1;
      wr.credit  <= 1'b0;
    end
    else
    begin
      if (wr.valid)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count      <= count + CNT_W'(wr.valid) - CNT_W'(pop);
      eng_credit <= (eng_credit && !pop) || rd.credit;
      wr.credit  <= pop;                     // slot freed upstream
    end
  end

  a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    wr.valid |-> count != CNT_W'(DEPTH));

  a_no_credit_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    rd.credit |-> !eng_credit);

endmodule

//--- smi_frame_engine.sv
`include "smi_settings.svh"

module smi_frame_engine (
  input  logic        clk,
  input  logic        rst_n,
  smi_cmd_if.dst      cmd,
  output logic        mdc,
  inout  wire         mdio,
  output logic        rdata_valid,
  output logic [15:0] rdata
);
  import smi_pkg::*;

  localparam int HALF     = (`SMI_REF_CLK_MHZ * 1000) / (2 * `SMI_MDC_KHZ);
  localparam int DIV_W    = (HALF > 1) ? $clog2(HALF) : 1;
  localparam int TA_BIT   = 46;   // first turnaround bit
  localparam int DATA_BIT = 48;   // first data bit

  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic             phase;        // internal mdc phase, free running
  logic             fall;
  logic             rise;
  logic             pending;      // command waiting for a falling phase
  smi_cmd_t         cmd_q;
  logic             busy;
  logic             is_read;
  logic [5:0]       bit_cnt;      // bit currently on the wire
  logic [63:0]      frame_sh;
  logic             mdio_oe;
  logic             start;
  logic             last;

  assign tick  = (div_cnt == DIV_W'(HALF - 1));
  assign fall  = tick && phase;
  assign rise  = tick && !phase;
  assign start = fall && pending && !busy;
  assign last  = fall && busy && (bit_cnt == 6'd63);

  assign mdio = mdio_oe ? frame_sh[63] : 1'bz;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
      phase   <= 1'b1;
    end
    else if (tick)
    begin
      div_cnt <= '0;
      phase   <= !phase;
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // mdc only toggles inside a frame, idles high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      mdc <= 1'b1;
    else if (fall)
      mdc <= !(start || (busy && !last));
    else if (rise)
      mdc <= 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pending <= 1'b0;
    else if (cmd.valid)
      pending <= 1'b1;
    else if (start)
      pending <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (cmd.valid)
      cmd_q <= cmd.cmd;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      is_read <= 1'b0;
      bit_cnt <= '0;
      mdio_oe <= 1'b0;
    end
    else if (start)
    begin
      busy    <= 1'b1;
      is_read <= (cmd_q.op == SMI_OP_READ);
      bit_cnt <= '0;
      mdio_oe <= 1'b1;
    end
    else if (last)
    begin
      busy    <= 1'b0;
      mdio_oe <= 1'b0;
    end
    else if (fall && busy)
    begin
      bit_cnt <= bit_cnt + 6'd1;
      if (is_read && (bit_cnt == 6'(TA_BIT - 1)))
        mdio_oe <= 1'b0;                     // phy owns the bus from TA on
    end
  end

  // preamble, start, op, phy, reg, turnaround, data
  always_ff @(posedge clk)
  begin
    if (start)
      frame_sh <= {32'hFFFF_FFFF, 2'b01, cmd_q.op, `SMI_PHY_ADDR,
                   cmd_q.reg_addr, 2'b10, cmd_q.wdata};
    else if (fall && busy)
      frame_sh <= {frame_sh[62:0], 1'b1};
  end

  always_ff @(posedge clk)
  begin
    if (rise && busy && is_read && (bit_cnt >= 6'(DATA_BIT)))
      rdata <= {rdata[14:0], mdio};          // msb first
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd.credit  <= 1'b0;
      rdata_valid <= 1'b0;
    end
    else
    begin
      cmd.credit  <= last;
      rdata_valid <= last && is_read;
    end
  end

  a_no_valid_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cmd.valid |-> !busy && !pending);

endmodule

//--- smi_subsystem.sv
module smi_subsystem (
  input  logic       clk,
  input  logic       rst_n,
  output logic       mdc,
  inout  wire        mdio,
  output logic       link,
  output logic [1:0] speed,
  output logic [1:0] led
);
  import smi_pkg::*;

  eth_speed_e  mon_speed;
  logic        rdata_valid;   // read frame done
  logic [15:0] rdata;

  smi_cmd_if mon_to_fifo ();
  smi_cmd_if fifo_to_eng ();

  smi_link_monitor i_smi_link_monitor (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (mon_to_fifo.src),
    .rdata_valid (rdata_valid),
    .rdata       (rdata),
    .link        (link),
    .speed       (mon_speed),
    .led         (led)
  );

  smi_cmd_fifo i_smi_cmd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (mon_to_fifo.dst),
    .rd    (fifo_to_eng.src)
  );

  smi_frame_engine i_smi_frame_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (fifo_to_eng.dst),
    .mdc         (mdc),
    .mdio        (mdio),
    .rdata_valid (rdata_valid),
    .rdata       (rdata)
  );

  assign speed = mon_speed;      // plain code at the pins

endmodule

//--- mdio_phy_model.sv
`include "smi_settings.svh"

module mdio_phy_model (
  input  logic        mdc,
  inout  wire         mdio,
  input  logic [15:0] status_word,    // answer for the next read
  output logic [63:0] frame,          // last complete frame, first bit in msb
  output int          write_cnt,
  output int          read_cnt,
  output int          per_min,        // shortest mdc period seen, time units
  output int          per_max
);

  logic [63:0] bits;
  int          idx;             // bit position of the next rising edge
  bit          armed;           // mdc fell since the last rise, x to 1 at reset is no bit
  logic        drv_en;
  logic        drv_val;
  logic [15:0] answer;
  time         t_last;
  int          per;

  event frame_start;
  event frame_end;

  assign mdio = drv_en ? drv_val : 1'bz;

  initial
  begin
    idx       = 0;
    armed     = 1'b0;
    drv_en    = 1'b0;
    drv_val   = 1'b1;
    frame     = '0;
    write_cnt = 0;
    read_cnt  = 0;
    per_min   = 0;
    per_max   = 0;
  end

  // the phy samples on rising mdc, mdc only toggles inside a frame
  always @(posedge mdc)
  begin
    if (armed)
    begin
      armed = 1'b0;
      if (idx == 0)
        -> frame_start;
      else
      begin
        per = int'($time - t_last);
        if ((per_min == 0) || (per < per_min))
          per_min = per;
        if (per > per_max)
          per_max = per;
      end
      t_last         = $time;
      bits[63 - idx] = mdio;
      if (idx == 63)
      begin
        drv_en = 1'b0;                // engine already sampled the last bit
        frame  = bits;
        if (bits[29:28] == 2'b01)
          write_cnt++;
        else if (bits[29:28] == 2'b10)
          read_cnt++;
        idx = 0;
        -> frame_end;
      end
      else
        idx++;
    end
  end

  // read data goes out after mdc falls, msb first
  always @(negedge mdc)
  begin
    armed = 1'b1;
    if ((idx == 47) && (bits[29:28] == 2'b10) && (bits[27:23] == `SMI_PHY_ADDR))
    begin
      answer  = status_word;
      drv_en  = 1'b1;
      drv_val = 1'b0;                 // second turnaround bit
    end
    else if (drv_en && (idx >= 48))
      drv_val = answer[63 - idx];
  end

endmodule

//--- tb_smi_subsystem.sv
`include "smi_settings.svh"

module tb_smi_subsystem;

  localparam int CLK_PERIOD = 20;
  localparam int MDC_CYCLES = (`SMI_REF_CLK_MHZ * 1000) / `SMI_MDC_KHZ;  // clk per mdc period

  logic        clk = 1'b0;
  logic        rst_n;
  logic        pull_low;        // probe that shows whether mdio is released
  logic [15:0] status_word;
  wire         mdc;
  wire         mdio;
  logic        link;
  logic [1:0]  speed;
  logic [1:0]  led;

  logic [63:0] frame;
  int          write_cnt;
  int          read_cnt;
  int          per_min;
  int          per_max;

  logic [15:0] row_word [$];
  logic        row_link [$];
  logic [1:0]  row_speed [$];
  logic [1:0]  row_led [$];

  int cycles = 0;
  int limit = 100;              // replaced once the stimulus is loaded
  int errors = 0;
  int tests = 0;
  int failed = 0;
  bit test_bad = 1'b0;

  pullup (mdio);
  assign mdio = pull_low ? 1'b0 : 1'bz;

  always #(CLK_PERIOD / 2) clk = ~clk;

  smi_subsystem i_smi_subsystem (
    .clk   (clk),
    .rst_n (rst_n),
    .mdc   (mdc),
    .mdio  (mdio),
    .link  (link),
    .speed (speed),
    .led   (led)
  );

  mdio_phy_model i_mdio_phy_model (
    .mdc         (mdc),
    .mdio        (mdio),
    .status_word (status_word),
    .frame       (frame),
    .write_cnt   (write_cnt),
    .read_cnt    (read_cnt),
    .per_min     (per_min),
    .per_max     (per_max)
  );

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= limit)
    begin
      $display("timeout: the run did not finish within %0d clock cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_bad = 1'b1;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (test_bad)
    begin
      failed++;
      $display("test %s: FAIL", name);
    end
    else
      $display("test %s: ok", name);
    test_bad = 1'b0;
  endtask

  // clause-22 layout: preamble, start, op, phy, reg, turnaround, data
  task automatic check_frame(input logic [1:0] op, input logic [4:0] reg_num);
    check_value("frame.preamble", frame[63:32], 32'hffff_ffff);
    check_value("frame.start", frame[31:30], 2'b01);
    check_value("frame.op", frame[29:28], op);
    check_value("frame.phy_addr", frame[27:23], `SMI_PHY_ADDR);
    check_value("frame.reg_addr", frame[22:18], reg_num);
  endtask

  task automatic load_stimulus();
    int          fd;
    logic [15:0] w;
    logic        l;
    logic [1:0]  s;
    logic [1:0]  d;
    fd = $fopen("smi_stim.txt", "r");
    if (fd != 0)
    begin
      while ($fscanf(fd, "%h %b %b %b\n", w, l, s, d) == 4)
      begin
        row_word.push_back(w);
        row_link.push_back(l);
        row_speed.push_back(s);
        row_led.push_back(d);
      end
      $fclose(fd);
    end
  endtask

  task automatic run_tests(input int n);
    repeat (8) @(posedge clk);
    pull_low    <= 1'b1;
    status_word <= row_word[0];
    @(negedge clk);
    check_value("mdio", mdio, 1'b0);          // nothing but the probe drives it
    check_value("link", link, 1'b0);
    check_value("speed", speed, 2'b11);
    check_value("led", led, 2'b11);
    check_value("mdc", mdc, 1'b1);
    @(posedge clk);
    pull_low <= 1'b0;
    @(negedge clk);
    check_value("mdio", mdio, 1'b1);          // pull-up alone lifts it
    finish_test("reset_state");
    repeat (7) @(posedge clk);
    rst_n <= 1'b1;

    @(i_mdio_phy_model.frame_end);
    check_frame(2'b01, `SMI_REG_CTRL);
    check_value("frame.ta", frame[17:16], 2'b10);
    check_value("frame.wdata", frame[15:0], `SMI_CTRL_VALUE);
    finish_test("config_write");

    for (int i = 0; i < n; i++)
    begin
      @(i_mdio_phy_model.frame_end);
      check_frame(2'b10, `SMI_REG_STATUS);
      if (i + 1 < n)
      begin
        @(posedge clk);
        status_word <= row_word[i + 1];     // answer for the following read
      end
      @(i_mdio_phy_model.frame_start);
      @(negedge clk);
      check_value("link", link, row_link[i]);
      check_value("speed", speed, row_speed[i]);
      check_value("led", led, row_led[i]);
      finish_test($sformatf("poll_%0d status %h", i, row_word[i]));
    end

    check_value("write_cnt", write_cnt, 1);
    check_value("read_cnt", read_cnt, n);
    finish_test("frame_counts");

    check_value("mdc_period_min", per_min / CLK_PERIOD, MDC_CYCLES);
    check_value("mdc_period_max", per_max / CLK_PERIOD, MDC_CYCLES);
    finish_test("mdc_rate");
  endtask

  initial
  begin
    rst_n       = 1'b0;
    pull_low    = 1'b0;
    status_word = 16'h0000;
    load_stimulus();
    limit = (row_word.size() + 2) * (`SMI_POLL_CYCLES + 64 * MDC_CYCLES + 20);
    if (row_word.size() == 0)
    begin
      $display("no stimulus rows could be read from smi_stim.txt");
      errors++;
    end
    else
      run_tests(row_word.size());
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if ((errors == 0) && (failed == 0))
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- smi_stim.txt
0400 1 00 10
4400 1 01 01
8400 1 10 00
c400 1 10 00
8000 0 10 11
4c00 1 01 01
0000 0 01 11
0402 1 00 10
ffff 1 10 00
3bff 0 10 11

//--- list.f
+incdir+.
smi_pkg.sv
smi_cmd_if.sv
smi_link_monitor.sv
smi_cmd_fifo.sv
smi_frame_engine.sv
smi_subsystem.sv
mdio_phy_model.sv
tb_smi_subsystem.sv

//--- Bender.yml
package:
  name: smi_subsystem

sources:
  - include_dirs:
      - .
    files:
      - smi_pkg.sv
      - smi_cmd_if.sv
      - smi_link_monitor.sv
      - smi_cmd_fifo.sv
      - smi_frame_engine.sv
      - smi_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - mdio_phy_model.sv
      - tb_smi_subsystem.sv
